//--- sqrt_unit.f
src/sqrt_pkg.sv
src/stream_stage.sv
src/sqrt_exponent.sv
src/sqrt_mantissa.sv
src/sqrt_round.sv
src/sqrt_unit.sv
dv/sqrt_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build the sqrt_unit testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sqrt_unit.f \
    --top-module sqrt_unit_tb \
    -Mdir obj_dir -o sim_sqrt_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_sqrt_unit
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- dv/sqrt_stimulus.txt
# operand mode tag expected_result expected_flags, all hex
# mode 0 RNE, 1 RTZ, 2 RDN, 3 RUP, 4 RMM; flags 10 is NV, 01 is NX
3f800000 0 01 3f800000 00
40800000 0 02 40000000 00
41100000 0 03 40400000 00
40100000 0 04 3fc00000 00
3e800000 0 05 3f000000 00
00000002 0 06 1a800000 00
00200000 0 07 1f800000 00
40000000 0 08 3fb504f3 01
40400000 0 09 3fddb3d7 01
41000000 0 0a 403504f3 01
00000001 0 0b 1a3504f3 01
00400000 0 0c 1fb504f3 01
40000000 1 0d 3fb504f3 01
40000000 2 0e 3fb504f3 01
40000000 3 0f 3fb504f4 01
40000000 4 10 3fb504f3 01
40a00000 0 11 400f1bbd 01
40a00000 1 12 400f1bbc 01
40a00000 2 13 400f1bbc 01
40a00000 3 14 400f1bbd 01
40a00000 4 15 400f1bbd 01
00000000 0 16 00000000 00
80000000 0 17 80000000 00
7f800000 0 18 7f800000 00
bf800000 0 19 7fc00000 10
ff800000 0 1a 7fc00000 10
7f800001 0 1b 7fc00000 10
7fc00000 0 1c 7fc00000 00
ffc12345 0 1d 7fc00000 00
80000001 0 1e 7fc00000 10

//--- dv/sqrt_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_unit_tb;

    localparam string STIM_FILE = "dv/sqrt_stimulus.txt";

    logic                    clk;
    logic                    rst_n;
    logic                    cmd_valid;
    logic                    cmd_ready;
    sqrt_pkg::sqrt_command_t cmd_payload;
    logic                    res_valid;
    logic                    res_ready;
    sqrt_pkg::sqrt_result_t  res_payload;

    sqrt_pkg::sqrt_command_t    cmd_q[$];
    logic [31:0]                want_result_q[$];
    logic [4:0]                 want_flags_q[$];
    logic [sqrt_pkg::TAG_W-1:0] want_tag_q[$];

    int          num_tests;
    int          cmd_idx;
    int          num_checked;
    logic        cmd_taken;           // Command transfers at the coming rising edge
    logic        loaded;

    sqrt_unit dut_i (
        .clk, .rst_n,
        .cmd_valid, .cmd_ready, .cmd_payload,
        .res_valid, .res_ready, .res_payload
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic load_stimulus();
        int                         fd;
        int                         count;
        string                      line;
        logic [31:0]                a;
        logic [2:0]                 mode;
        logic [sqrt_pkg::TAG_W-1:0] tag;
        logic [31:0]                result;
        logic [4:0]                 flags;
        sqrt_pkg::sqrt_command_t    cmd;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run($sformatf("Could not open stimulus file %s", STIM_FILE));
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) != "#") begin
                    count = $sscanf(line, "%h %h %h %h %h", a, mode, tag, result, flags);
                    if (count == 5) begin
                        cmd.a        = a;
                        cmd.mode     = mode;
                        cmd.dest_reg = tag;
                        cmd_q.push_back(cmd);
                        want_result_q.push_back(result);
                        want_flags_q.push_back(flags);
                        want_tag_q.push_back(tag);
                    end
                end
            end
            $fclose(fd);
            num_tests = cmd_q.size();
        end
    endtask

    // Payload seen here is what transfers at the next rising edge
    task automatic check_result();
        logic [31:0]                want_result;
        logic [4:0]                 want_flags;
        logic [sqrt_pkg::TAG_W-1:0] want_tag;
        assert (want_result_q.size() > 0)
            else abort_run("DUT returned a result with no command outstanding");
        want_result = want_result_q.pop_front();
        want_flags  = want_flags_q.pop_front();
        want_tag    = want_tag_q.pop_front();
        assert (res_payload.dest_reg == want_tag)
            else abort_run($sformatf("** Error @ %0t: result %0d has tag %0h, expected %0h",
                                     $time, num_checked, res_payload.dest_reg, want_tag));
        assert (res_payload.result == want_result)
            else abort_run($sformatf("** Error @ %0t: tag %0h result %h, expected %h",
                                     $time, want_tag, res_payload.result, want_result));
        assert (res_payload.flags == want_flags)
            else abort_run($sformatf("** Error @ %0t: tag %0h flags %h, expected %h",
                                     $time, want_tag, res_payload.flags, want_flags));
        num_checked++;
    endtask

    initial begin
        void'($urandom(32'h8f19_93cf));
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_payload = '0;
        res_ready   = 1'b0;
        cmd_idx     = 0;
        num_checked = 0;
        num_tests   = 0;
        cmd_taken   = 1'b0;
        loaded      = 1'b0;
        load_stimulus();
        assert (num_tests > 0)
            else abort_run("Stimulus file holds no tests");
        loaded = 1'b1;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (res_valid == 1'b0)
            else abort_run($sformatf("** Error @ %0t: res_valid high after reset", $time));
        assert (cmd_ready == 1'b1)
            else abort_run($sformatf("** Error @ %0t: cmd_ready low after reset", $time));

        while (num_checked < num_tests) begin
            if (cmd_taken) begin
                cmd_idx++;
                cmd_valid = 1'b0;
            end
            if (!cmd_valid && cmd_idx < num_tests && ($urandom % 4) != 0) begin
                cmd_valid   = 1'b1;                  // Random gaps between commands
                cmd_payload = cmd_q[cmd_idx];
            end
            cmd_taken = cmd_valid && cmd_ready;
            res_ready = ($urandom % 2) == 0;         // Random back-pressure
            if (res_valid && res_ready) begin
                check_result();
            end
            @(negedge clk);
        end

        // A repeated last result would show up here
        res_ready = 1'b1;
        repeat (4) begin
            assert (res_valid == 1'b0)
                else abort_run("DUT returned a result after every command was answered");
            @(negedge clk);
        end

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (num_tests * 40 + 200) @(posedge clk);
        abort_run($sformatf("Watchdog expired, results stopped arriving after %0d of %0d",
                            num_checked, num_tests));
    end

endmodule

`default_nettype wire

//--- src/sqrt_unit.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_unit (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  sqrt_pkg::sqrt_command_t cmd_payload,

    output logic                    res_valid,
    input  logic                    res_ready,
    output sqrt_pkg::sqrt_result_t  res_payload
);

    logic                      exp_valid, exp_ready;
    sqrt_pkg::sqrt_operation_t exp_payload;

    logic                      op_valid, op_ready;
    sqrt_pkg::sqrt_operation_t op_payload;

    logic                      root_valid, root_ready;
    sqrt_pkg::sqrt_root_t      root_payload;

    logic                      rnd_valid, rnd_ready;
    sqrt_pkg::sqrt_result_t    rnd_payload;

    sqrt_exponent exponent_i (
        .cmd_valid, .cmd_ready, .cmd_payload,
        .op_valid(exp_valid), .op_ready(exp_ready), .op_payload(exp_payload)
    );

    stream_stage #(
        .T(sqrt_pkg::sqrt_operation_t),
        .MODE(1)
    ) op_stage_i (
        .clk, .rst_n,
        .in_valid(exp_valid), .in_ready(exp_ready), .in_payload(exp_payload),
        .out_valid(op_valid), .out_ready(op_ready), .out_payload(op_payload)
    );

    sqrt_mantissa mantissa_i (
        .clk, .rst_n,
        .op_valid, .op_ready, .op_payload,
        .root_valid, .root_ready, .root_payload
    );

    sqrt_round round_i (
        .root_valid, .root_ready, .root_payload,
        .res_valid(rnd_valid), .res_ready(rnd_ready), .res_payload(rnd_payload)
    );

    stream_stage #(
        .T(sqrt_pkg::sqrt_result_t),
        .MODE(1)
    ) res_stage_i (
        .clk, .rst_n,
        .in_valid(rnd_valid), .in_ready(rnd_ready), .in_payload(rnd_payload),
        .out_valid(res_valid), .out_ready(res_ready), .out_payload(res_payload)
    );

endmodule

`default_nettype wire

//--- src/sqrt_round.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_round (
    input  logic                   root_valid,
    output logic                   root_ready,
    input  sqrt_pkg::sqrt_root_t   root_payload,

    output logic                   res_valid,
    input  logic                   res_ready,
    output sqrt_pkg::sqrt_result_t res_payload
);

    logic [23:0] mant;                    // 1.f with integer bit at 23
    logic        guard;
    logic        round_bit;
    logic        sticky;
    logic        inexact;
    logic        round_up;
    logic [24:0] sum;
    logic [22:0] frac;

    logic [sqrt_pkg::EXP_W-1:0] exp_adj;

    assign res_valid  = root_valid;
    assign root_ready = res_ready;

    assign mant      = root_payload.root[sqrt_pkg::ROOT_W-1:2];
    assign guard     = root_payload.root[1];
    assign round_bit = root_payload.root[0];
    assign sticky    = root_payload.sticky;
    assign inexact   = guard || round_bit || sticky;

    // Result is always positive, so RDN truncates and RUP rounds away
    always_comb begin
        case (root_payload.mode)
            sqrt_pkg::RM_RNE: round_up = guard && (round_bit || sticky || mant[0]);
            sqrt_pkg::RM_RTZ: round_up = 1'b0;
            sqrt_pkg::RM_RDN: round_up = 1'b0;
            sqrt_pkg::RM_RUP: round_up = inexact;
            sqrt_pkg::RM_RMM: round_up = guard;
            default:          round_up = 1'b0;
        endcase
    end

    assign sum = {1'b0, mant} + {24'd0, round_up};

    // Carry out wraps the significand to 2.0 and leaves a zero fraction
    assign frac    = sum[22:0];
    assign exp_adj = root_payload.exponent + {{(sqrt_pkg::EXP_W-1){1'b0}}, sum[24]};

    always_comb begin
        res_payload.flags    = 5'd0;
        res_payload.dest_reg = root_payload.dest_reg;
        if (root_payload.special) begin
            res_payload.result                  = root_payload.special_result;
            res_payload.flags[sqrt_pkg::FLAG_NV] = root_payload.special_nv;
        end else begin
            res_payload.result                  = {1'b0, exp_adj[7:0], frac};
            res_payload.flags[sqrt_pkg::FLAG_NX] = inexact;
        end
    end

endmodule

`default_nettype wire

//--- src/sqrt_mantissa.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_mantissa (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      op_valid,
    output logic                      op_ready,
    input  sqrt_pkg::sqrt_operation_t op_payload,

    output logic                      root_valid,
    input  logic                      root_ready,
    output sqrt_pkg::sqrt_root_t      root_payload
);

    localparam int REM_W = sqrt_pkg::ROOT_W + 3;
    localparam int CNT_W = $clog2(sqrt_pkg::ROOT_W);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(sqrt_pkg::ROOT_W - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_HOLD
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] count;
    logic             accept;

    logic [sqrt_pkg::RAD_W-1:0]  rad_q;   // Radicand bits still to bring down
    logic [sqrt_pkg::ROOT_W-1:0] root_q;
    logic [REM_W-1:0]            rem_q;

    logic                        special_q;
    logic [31:0]                 special_result_q;
    logic                        special_nv_q;
    logic [sqrt_pkg::EXP_W-1:0]  exponent_q;
    logic [2:0]                  mode_q;
    logic [sqrt_pkg::TAG_W-1:0]  dest_reg_q;

    logic [REM_W-1:0] shifted;
    logic [REM_W-1:0] trial;
    logic [REM_W-1:0] diff;
    logic             take;

    assign op_ready   = (state == S_IDLE);
    assign root_valid = (state == S_HOLD);
    assign accept     = op_valid && op_ready;

    // Remainder stays below 2*root+1, so the top two bits dropped here are zero
    assign shifted = {rem_q[REM_W-3:0], rad_q[sqrt_pkg::RAD_W-1 -: 2]};
    assign trial   = {1'b0, root_q, 2'b01};
    assign diff    = shifted - trial;
    assign take    = (shifted >= trial);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (op_valid) begin
                        count <= '0;
                        state <= op_payload.special ? S_HOLD : S_BUSY;
                    end
                end
                S_BUSY: begin
                    count <= count + 1'b1;
                    if (count == LAST) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (root_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rad_q            <= op_payload.radicand;
            root_q           <= '0;                   // Zero root for specials
            rem_q            <= '0;
            special_q        <= op_payload.special;
            special_result_q <= op_payload.special_result;
            special_nv_q     <= op_payload.special_nv;
            exponent_q       <= op_payload.exponent;
            mode_q           <= op_payload.mode;
            dest_reg_q       <= op_payload.dest_reg;
        end else if (state == S_BUSY) begin
            rad_q  <= {rad_q[sqrt_pkg::RAD_W-3:0], 2'b00};
            root_q <= {root_q[sqrt_pkg::ROOT_W-2:0], take};
            rem_q  <= take ? diff : shifted;
        end
    end

    always_comb begin
        root_payload.root           = root_q;
        root_payload.sticky         = |rem_q;
        root_payload.special        = special_q;
        root_payload.special_result = special_result_q;
        root_payload.special_nv     = special_nv_q;
        root_payload.exponent       = exponent_q;
        root_payload.mode           = mode_q;
        root_payload.dest_reg       = dest_reg_q;
    end

endmodule

`default_nettype wire

//--- src/sqrt_exponent.sv
`timescale 1ns/1ps
`default_nettype none

module sqrt_exponent (
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    input  sqrt_pkg::sqrt_command_t   cmd_payload,

    output logic                      op_valid,
    input  logic                      op_ready,
    output sqrt_pkg::sqrt_operation_t op_payload
);

    logic        sign;
    logic [7:0]  exp_field;
    logic [22:0] frac;

    logic is_zero, is_sub, is_inf, is_qnan, is_snan;

    logic [4:0]        lz;
    logic [23:0]       sig;               // Normalized significand 1.f
    logic signed [9:0] unb_exp;
    logic signed [9:0] even_exp;
    logic signed [9:0] res_exp;
    logic              odd;

    function automatic logic [4:0] lead_zeros(input logic [22:0] f);
        logic [4:0] n;
        logic       found;
        n     = 5'd0;
        found = 1'b0;
        for (int i = 22; i >= 0; i--) begin
            if (!found) begin
                if (f[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 5'd1;
                end
            end
        end
        return n;
    endfunction

    assign op_valid  = cmd_valid;
    assign cmd_ready = op_ready;

    assign sign      = cmd_payload.a[31];
    assign exp_field = cmd_payload.a[30:23];
    assign frac      = cmd_payload.a[22:0];

    assign is_zero = (exp_field == 8'd0) && (frac == 23'd0);
    assign is_sub  = (exp_field == 8'd0) && (frac != 23'd0);
    assign is_inf  = (exp_field == 8'hff) && (frac == 23'd0);
    assign is_qnan = (exp_field == 8'hff) && frac[22];
    assign is_snan = (exp_field == 8'hff) && !frac[22] && (frac != 23'd0);

    assign lz = lead_zeros(frac);

    always_comb begin
        if (is_sub) begin
            sig     = {1'b0, frac} << (lz + 5'd1);        // Leading one to bit 23
            unb_exp = -10'sd127 - $signed({5'b00000, lz});
        end else begin
            sig     = {1'b1, frac};
            unb_exp = $signed({2'b00, exp_field}) - 10'sd127;
        end
    end

    // Odd exponent moves one factor of two into the significand
    assign odd      = unb_exp[0];
    assign even_exp = odd ? unb_exp - 10'sd1 : unb_exp;
    assign res_exp  = (even_exp >>> 1) + 10'sd127;

    always_comb begin
        op_payload.special        = 1'b1;
        op_payload.special_result = sqrt_pkg::CANONICAL_NAN;
        op_payload.special_nv     = 1'b0;
        if (is_snan) begin
            op_payload.special_nv = 1'b1;
        end else if (is_qnan) begin
            op_payload.special_nv = 1'b0;
        end else if (is_zero) begin
            op_payload.special_result = cmd_payload.a;    // Signed zero kept
        end else if (sign) begin
            op_payload.special_nv = 1'b1;                 // Includes -inf
        end else if (is_inf) begin
            op_payload.special_result = cmd_payload.a;
        end else begin
            op_payload.special = 1'b0;
        end

        op_payload.exponent = res_exp;
        op_payload.radicand = odd ? {sig, 2'b00} : {1'b0, sig, 1'b0};
        op_payload.mode     = cmd_payload.mode;
        op_payload.dest_reg = cmd_payload.dest_reg;
    end

endmodule

`default_nettype wire

//--- src/stream_stage.sv
`timescale 1ns/1ps
`default_nettype none

module stream_stage #(
    parameter type T    = logic,
    parameter int  MODE = 1              // 0 pass-through, 1 registered
)(
    input  logic clk,
    input  logic rst_n,

    input  logic in_valid,
    output logic in_ready,
    input  T     in_payload,

    output logic out_valid,
    input  logic out_ready,
    output T     out_payload
);

    generate
        if (MODE == 0) begin : g_pass
            assign out_valid   = in_valid;
            assign in_ready    = out_ready;
            assign out_payload = in_payload;
        end else begin : g_reg
            logic full;
            T     data;

            // Take a new payload when empty or when the held one leaves now
            assign in_ready = !full || out_ready;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    full <= 1'b0;
                end else if (in_ready) begin
                    full <= in_valid;
                end
            end

            always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                    data <= in_payload;
                end
            end

            assign out_valid   = full;
            assign out_payload = data;
        end
    endgenerate

endmodule

`default_nettype wire

//--- src/sqrt_pkg.sv
`default_nettype none

package sqrt_pkg;

    localparam int TAG_W  = 5;           // Destination register tag
    localparam int ROOT_W = 26;          // 24 significand bits, guard and round
    localparam int EXP_W  = 10;          // Biased result exponent with headroom
    localparam int RAD_W  = 26;          // Radicand, 2 integer and 24 fraction bits

    // Resolved rounding modes, RV32F encoding
    localparam logic [2:0] RM_RNE = 3'b000;
    localparam logic [2:0] RM_RTZ = 3'b001;
    localparam logic [2:0] RM_RDN = 3'b010;
    localparam logic [2:0] RM_RUP = 3'b011;
    localparam logic [2:0] RM_RMM = 3'b100;

    localparam int FLAG_NV = 4;          // fflags bit positions
    localparam int FLAG_NX = 0;

    localparam logic [31:0] CANONICAL_NAN = 32'h7fc0_0000;

    typedef struct packed {
        logic [31:0]      a;
        logic [2:0]       mode;
        logic [TAG_W-1:0] dest_reg;
    } sqrt_command_t;

    typedef struct packed {
        logic             special;        // Result known without iteration
        logic [31:0]      special_result;
        logic             special_nv;
        logic [EXP_W-1:0] exponent;
        logic [RAD_W-1:0] radicand;
        logic [2:0]       mode;
        logic [TAG_W-1:0] dest_reg;
    } sqrt_operation_t;

    typedef struct packed {
        logic [ROOT_W-1:0] root;
        logic              sticky;        // Final remainder nonzero
        logic              special;
        logic [31:0]       special_result;
        logic              special_nv;
        logic [EXP_W-1:0]  exponent;
        logic [2:0]        mode;
        logic [TAG_W-1:0]  dest_reg;
    } sqrt_root_t;

    typedef struct packed {
        logic [31:0]      result;
        logic [4:0]       flags;
        logic [TAG_W-1:0] dest_reg;
    } sqrt_result_t;

endpackage

`default_nettype wire
